// File: conv_front.f
rtl/conv_front_pkg.sv
rtl/conv_front_ctrl.sv
rtl/conv_loop_counter.sv
rtl/pixel_buffer.sv
rtl/weight_buffer.sv
rtl/mac_row.sv
rtl/conv_datapath_front.sv
verification/conv_front_tb.sv

// File: rtl/conv_datapath_front.sv
`timescale 1ns/10ps

module conv_datapath_front import conv_front_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en,
    input  conv_cfg_t cfg,
    input  pix_wr_t   pix_wr,
    input  wgt_wr_t   wgt_wr,
    output out_row_t  out_row,
    output logic      out_valid,
    output logic      busy
);

    conv_cfg_t        job_cfg;
    logic             cnt_start, cnt_run, cnt_done;
    pix_addr_t        pix_rd_addr;
    wgt_addr_t        wgt_rd_addr;
    logic             term_valid, term_first, term_last;
    pixel_t [pox-1:0] pix_window;
    weight_t          wgt_word;

    ////////////////////
    // control
    ////////////////////
    conv_front_ctrl conv_front_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .cfg       (cfg),
        .cnt_done  (cnt_done),
        .out_valid (out_valid),
        .job_cfg   (job_cfg),
        .cnt_start (cnt_start),
        .cnt_run   (cnt_run),
        .busy      (busy)
    );

    conv_loop_counter conv_loop_counter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cnt_start   (cnt_start),
        .cnt_run     (cnt_run),
        .job_cfg     (job_cfg),
        .pix_rd_addr (pix_rd_addr),
        .wgt_rd_addr (wgt_rd_addr),
        .term_valid  (term_valid),   // delayed to meet buffer data
        .term_first  (term_first),
        .term_last   (term_last),
        .cnt_done    (cnt_done)
    );

    ////////////////////
    // storage + mac
    ////////////////////
    pixel_buffer pixel_buffer_i (
        .clk     (clk),
        .pix_wr  (pix_wr),
        .rd_addr (pix_rd_addr),
        .window  (pix_window)
    );

    weight_buffer weight_buffer_i (
        .clk     (clk),
        .wgt_wr  (wgt_wr),
        .rd_addr (wgt_rd_addr),
        .rd_data (wgt_word)
    );

    mac_row mac_row_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mode       (job_cfg.mode),
        .term_valid (term_valid),
        .term_first (term_first),
        .term_last  (term_last),
        .window     (pix_window),
        .wgt_word   (wgt_word),
        .out_row    (out_row),
        .out_valid  (out_valid)
    );

    // buffers are loaded only between jobs
    a_wr_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (pix_wr.en || wgt_wr.en) |-> !busy);

endmodule

// File: rtl/conv_front_ctrl.sv
`timescale 1ns/10ps

module conv_front_ctrl import conv_front_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en,
    input  conv_cfg_t cfg,
    input  logic      cnt_done,
    input  logic      out_valid,
    output conv_cfg_t job_cfg,
    output logic      cnt_start,
    output logic      cnt_run,
    output logic      busy
);

    ctrl_state_t state;
    logic        drain_armed;   // set after the first drain cycle

    assign cnt_start = (state == st_idle) && en;   // en ignored outside idle
    assign cnt_run   = (state == st_run);
    assign busy      = (state != st_idle);

    // config held for the whole job
    always_ff @(posedge clk) begin
        if (cnt_start) job_cfg <= cfg;
    end

    ////////////////////
    // job fsm
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            drain_armed <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (en) state <= st_run;
                end
                st_run: begin
                    drain_armed <= 1'b0;
                    if (cnt_done) state <= st_drain;    // final term issued
                end
                st_drain: begin
                    // first drain cycle may still see the previous group's strobe
                    drain_armed <= 1'b1;
                    if (drain_armed && out_valid) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // a start pulse mid run must not disturb the job
    a_en_ignored: assert property (@(posedge clk) disable iff (!rst_n)
        (en && state == st_run) |=> $stable(job_cfg) && busy);

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {st_idle, st_run, st_drain});

endmodule

// File: rtl/conv_front_pkg.sv
package conv_front_pkg;

    ////////////////////
    // size limits
    ////////////////////
    localparam int pox          = 4;    // output pixels per group
    localparam int max_nif      = 4;    // input channels
    localparam int max_ix       = 16;   // row width
    localparam int max_iy       = 8;    // column height
    localparam int pix_depth    = max_nif * max_iy * max_ix;  // 512
    localparam int wgt_depth    = max_nif * 9;                // 3x3 kernel per channel
    localparam int acc_headroom = 8;    // growth over nif*k*k terms

    ////////////////////
    // widths
    ////////////////////
    typedef logic [7:0] pixel_t;                             // unsigned
    typedef logic [7:0] weight_t;  // mode 0 signed, mode 1 bit0 ch0 / bit1 ch1
    typedef logic signed [16+acc_headroom-1:0] acc_t;        // product + headroom
    typedef logic [8:0] pix_addr_t;
    typedef logic [5:0] wgt_addr_t;
    typedef logic [4:0] dim_t;                               // ix, iy, oy, k, columns

    // pixel address  = (c * iy + y) * ix + x
    // weight address = (c * k + ky) * k + kx
    // ox = ix - k + 1, must be a multiple of pox

    typedef struct packed {
        dim_t       k;      // 1 or 3
        dim_t       ix;
        dim_t       iy;
        dim_t       oy;     // output rows
        logic [2:0] nif;    // 1..max_nif
        logic       mode;   // 0: 8x8 signed, 1: binary +/-
    } conv_cfg_t;

    typedef struct packed {
        logic      en;
        pix_addr_t addr;
        pixel_t    data;
    } pix_wr_t;

    typedef struct packed {
        logic      en;
        wgt_addr_t addr;
        weight_t   data;
    } wgt_wr_t;

    typedef struct packed {
        acc_t [pox-1:0] ch0;
        acc_t [pox-1:0] ch1;    // zero in mode 0
    } out_row_t;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain
    } ctrl_state_t;

endpackage

// File: rtl/conv_loop_counter.sv
`timescale 1ns/10ps

module conv_loop_counter import conv_front_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cnt_start,
    input  logic      cnt_run,
    input  conv_cfg_t job_cfg,
    output pix_addr_t pix_rd_addr,
    output wgt_addr_t wgt_rd_addr,
    output logic      term_valid,
    output logic      term_first,
    output logic      term_last,
    output logic      cnt_done
);

    dim_t       kx, ky;     // kernel position
    logic [2:0] c;          // input channel
    dim_t       col;        // first column of the group, steps of pox
    dim_t       row;        // output row
    dim_t       ox;
    dim_t       k_m1;
    dim_t       y_pos, x_pos;
    logic       kx_last, ky_last, c_last, col_last, row_last;
    logic       first_c, last_c;

    assign ox   = job_cfg.ix - job_cfg.k + dim_t'(1);
    assign k_m1 = job_cfg.k - dim_t'(1);

    assign kx_last  = (kx == k_m1);
    assign ky_last  = (ky == k_m1);
    assign c_last   = (c == job_cfg.nif - 3'd1);
    assign col_last = (col == ox - dim_t'(pox));
    assign row_last = (row == job_cfg.oy - dim_t'(1));

    assign first_c  = (kx == '0) && (ky == '0) && (c == '0);
    assign last_c   = kx_last && ky_last && c_last;
    assign cnt_done = cnt_run && last_c && col_last && row_last;  // final term of job

    ////////////////////
    // addresses
    ////////////////////
    assign y_pos = row + ky;
    assign x_pos = col + kx;    // window base, buffer adds 0..pox-1

    assign pix_rd_addr = (pix_addr_t'(c) * pix_addr_t'(job_cfg.iy) + pix_addr_t'(y_pos))
                         * pix_addr_t'(job_cfg.ix) + pix_addr_t'(x_pos);
    assign wgt_rd_addr = (wgt_addr_t'(c) * wgt_addr_t'(job_cfg.k) + wgt_addr_t'(ky))
                         * wgt_addr_t'(job_cfg.k) + wgt_addr_t'(kx);

    ////////////////////
    // nested counters
    ////////////////////
    // kx innermost, row outermost; all wrap to zero after the last term
    always_ff @(posedge clk) begin
        if (!rst_n || cnt_start) begin
            kx  <= '0;
            ky  <= '0;
            c   <= '0;
            col <= '0;
            row <= '0;
        end else if (cnt_run) begin
            if (!kx_last) kx <= kx + dim_t'(1);
            else begin
                kx <= '0;
                if (!ky_last) ky <= ky + dim_t'(1);
                else begin
                    ky <= '0;
                    if (!c_last) c <= c + 3'd1;
                    else begin
                        c <= '0;
                        if (!col_last) col <= col + dim_t'(pox);
                        else begin
                            col <= '0;
                            row <= row_last ? dim_t'(0) : row + dim_t'(1);
                        end
                    end
                end
            end
        end
    end

    // flags one cycle late, aligned with buffer data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            term_valid <= 1'b0;
            term_first <= 1'b0;
            term_last  <= 1'b0;
        end else begin
            term_valid <= cnt_run;
            term_first <= cnt_run && first_c;
            term_last  <= cnt_run && last_c;
        end
    end

    // job_cfg is latched on the start edge, so check it one cycle later
    a_ox_multiple: assert property (@(posedge clk) disable iff (!rst_n)
        cnt_start |=> (ox % dim_t'(pox)) == '0);

    a_cfg_limits: assert property (@(posedge clk) disable iff (!rst_n)
        cnt_start |=> job_cfg.ix <= max_ix && job_cfg.iy <= max_iy
                      && job_cfg.nif <= max_nif && job_cfg.nif != '0);

endmodule

// File: rtl/mac_row.sv
`timescale 1ns/10ps

module mac_row import conv_front_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mode,
    input  logic             term_valid,
    input  logic             term_first,
    input  logic             term_last,
    input  pixel_t [pox-1:0] window,
    input  weight_t          wgt_word,
    output out_row_t         out_row,
    output logic             out_valid
);

    acc_t acc0 [pox];   // lane 0 running sums
    acc_t acc1 [pox];   // lane 1, mode 1 only
    acc_t nxt0 [pox];
    acc_t nxt1 [pox];

    ////////////////////
    // per element term
    ////////////////////
    always_comb begin
        acc_t pix_s;
        acc_t wgt_s;
        acc_t term0;
        acc_t term1;
        wgt_s = acc_t'(signed'(wgt_word));    // sign extend for mode 0
        for (int i = 0; i < pox; i++) begin
            pix_s = acc_t'(window[i]);        // pixels are unsigned
            if (!mode) begin
                term0 = pix_s * wgt_s;
                term1 = '0;
            end else begin
                term0 = wgt_word[0] ? pix_s : -pix_s;   // 1 adds, 0 subtracts
                term1 = wgt_word[1] ? pix_s : -pix_s;
            end
            // first term of a group restarts the sum
            nxt0[i] = term_first ? term0 : acc0[i] + term0;
            nxt1[i] = term_first ? term1 : acc1[i] + term1;
        end
    end

    // running sums and result row
    always_ff @(posedge clk) begin
        for (int i = 0; i < pox; i++) begin
            if (term_valid) begin
                acc0[i] <= nxt0[i];
                acc1[i] <= nxt1[i];
            end
            if (term_valid && term_last) begin
                out_row.ch0[i] <= nxt0[i];  // completed group
                out_row.ch1[i] <= nxt1[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) out_valid <= 1'b0;
        else        out_valid <= term_valid && term_last;
    end

endmodule

// File: rtl/pixel_buffer.sv
`timescale 1ns/10ps

module pixel_buffer import conv_front_pkg::*; (
    input  logic                 clk,
    input  pix_wr_t              pix_wr,
    input  pix_addr_t            rd_addr,
    output pixel_t [pox-1:0]     window
);

    pixel_t mem [pix_depth];    // c-major, then y, then x

    // write port, only while idle
    always_ff @(posedge clk) begin
        if (pix_wr.en) mem[pix_wr.addr] <= pix_wr.data;
    end

    ////////////////////
    // window read
    ////////////////////
    // pox neighbours in one row, registered
    always_ff @(posedge clk) begin
        for (int i = 0; i < pox; i++) begin
            window[i] <= mem[rd_addr + pix_addr_t'(i)];
        end
    end

    // counter must never ask for pixels past the array end
    a_window_in_range: assert property (@(posedge clk)
        !$isunknown(rd_addr) |-> (int'(rd_addr) + pox) <= pix_depth);

endmodule

// File: rtl/weight_buffer.sv
`timescale 1ns/10ps

module weight_buffer import conv_front_pkg::*; (
    input  logic      clk,
    input  wgt_wr_t   wgt_wr,
    input  wgt_addr_t rd_addr,
    output weight_t   rd_data
);

    weight_t mem [wgt_depth];   // (c*k + ky)*k + kx

    always_ff @(posedge clk) begin
        if (wgt_wr.en) mem[wgt_wr.addr] <= wgt_wr.data;
    end

    // one word per term, same latency as the pixel window
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verification/conv_front_tb.sv
`timescale 1ns/10ps

module conv_front_tb import conv_front_pkg::*; ();

    logic      clk;
    logic      rst_n;
    logic      en;
    conv_cfg_t cfg;
    pix_wr_t   pix_wr;
    wgt_wr_t   wgt_wr;
    out_row_t  out_row;
    logic      out_valid;
    logic      busy;

    int          cycle = 0;                 // posedges so far
    int          errors = 0;
    logic [15:0] lfsr_state = 16'd62913;
    pixel_t      pix_mem [pix_depth];       // model copy of the feature map
    weight_t     wgt_mem [wgt_depth];

    ////////////////////
    // job table
    ////////////////////
    typedef struct packed {
        conv_cfg_t cfg;     // k, ix, iy, oy, nif, mode
        logic      poke;    // extra en pulse mid job
    } job_t;

    localparam int n_jobs = 5;

    job_t job_tab [n_jobs] = '{
        '{'{5'd1, 5'd8,  5'd2, 5'd2, 3'd1, 1'b0}, 1'b0},   // 1x1, single channel
        '{'{5'd3, 5'd10, 5'd5, 5'd3, 3'd4, 1'b0}, 1'b0},   // 3x3, four channels
        '{'{5'd3, 5'd6,  5'd4, 5'd2, 3'd2, 1'b1}, 1'b1},   // binary, en while busy
        '{'{5'd1, 5'd12, 5'd3, 5'd3, 3'd3, 1'b1}, 1'b0},   // new cfg after the poke
        '{'{5'd3, 5'd14, 5'd6, 5'd4, 3'd1, 1'b0}, 1'b0}
    };

    conv_datapath_front conv_datapath_front_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .cfg       (cfg),
        .pix_wr    (pix_wr),
        .wgt_wr    (wgt_wr),
        .out_row   (out_row),
        .out_valid (out_valid),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////
    // helpers
    ////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) b = {b[6:0], lfsr_bit()};
        return b;
    endfunction

    function automatic int terms(conv_cfg_t jc);
        return int'(jc.nif) * int'(jc.k) * int'(jc.k);   // per group
    endfunction

    function automatic int num_results(conv_cfg_t jc);
        return int'(jc.oy) * (int'(jc.ix) - int'(jc.k) + 1) / pox;
    endfunction

    // loads, job lengths and idle cycles of the whole table
    function automatic int job_budget();
        int total;
        total = 10;                                        // reset
        foreach (job_tab[j]) begin
            total += int'(job_tab[j].cfg.nif) * int'(job_tab[j].cfg.iy)
                     * int'(job_tab[j].cfg.ix) + 2;
            total += num_results(job_tab[j].cfg) * terms(job_tab[j].cfg) + 5;
        end
        return total + 100;
    endfunction

    // reference sum for result r, groups in row-major order
    function automatic out_row_t model_row(conv_cfg_t jc, int r);
        out_row_t res;
        int       ix, iy, k, groups, row, col, p, s0, s1;
        weight_t  wd;
        ix     = int'(jc.ix);
        iy     = int'(jc.iy);
        k      = int'(jc.k);
        groups = (ix - k + 1) / pox;
        row    = r / groups;
        col    = (r % groups) * pox;
        for (int i = 0; i < pox; i++) begin
            s0 = 0;
            s1 = 0;
            for (int c = 0; c < int'(jc.nif); c++) begin
                for (int ky = 0; ky < k; ky++) begin
                    for (int kx = 0; kx < k; kx++) begin
                        p  = int'(pix_mem[(c * iy + row + ky) * ix + col + i + kx]);
                        wd = wgt_mem[(c * k + ky) * k + kx];
                        if (!jc.mode) begin
                            s0 += p * int'($signed(wd));    // signed 8x8
                        end else begin
                            s0 += wd[0] ? p : -p;
                            s1 += wd[1] ? p : -p;
                        end
                    end
                end
            end
            res.ch0[i] = acc_t'(s0);
            res.ch1[i] = acc_t'(s1);
        end
        return res;
    endfunction

    ////////////////////
    // compares
    ////////////////////
    task automatic report_error(string msg);
        errors++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_row(out_row_t got, out_row_t exp, string what);
        if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_count(dim_t got, dim_t exp, string what);
        if (got !== exp) report_error($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic compare_flag(logic got, logic exp, string what);
        if (got !== exp) report_error($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    ////////////////////
    // job steps
    ////////////////////
    // pixel count always covers the weight count, so both load in one pass
    task automatic load_buffers(conv_cfg_t jc);
        int      npix;
        int      nwgt;
        pixel_t  pv;
        weight_t wv;
        npix = int'(jc.nif) * int'(jc.iy) * int'(jc.ix);
        nwgt = terms(jc);
        for (int a = 0; a < npix; a++) begin
            @(posedge clk);
            #1;
            pv         = rand_byte();
            pix_mem[a] = pv;
            pix_wr     = '{1'b1, pix_addr_t'(a), pv};
            wgt_wr.en  = 1'b0;
            if (a < nwgt) begin
                wv = '0;
                if (jc.mode) begin
                    wv[0] = lfsr_bit();     // ch0 sign bit
                    wv[1] = lfsr_bit();     // ch1 sign bit
                end else begin
                    wv = rand_byte();
                end
                wgt_mem[a] = wv;
                wgt_wr     = '{1'b1, wgt_addr_t'(a), wv};
            end
            @(negedge clk);
            compare_flag(busy, 1'b0, "busy while loading");
            compare_flag(out_valid, 1'b0, "out_valid while loading");
        end
    endtask

    task automatic run_job(int j);
        conv_cfg_t jc;
        int        n, total, t_en, last, got, d;
        logic      exp_valid, exp_busy;
        jc    = job_tab[j].cfg;
        n     = terms(jc);
        total = num_results(jc);
        cfg   = jc;
        load_buffers(jc);
        @(posedge clk);
        #1;
        pix_wr.en = 1'b0;
        wgt_wr.en = 1'b0;
        en        = 1'b1;
        t_en      = cycle;
        last      = t_en + 2 + total * n;     // final strobe
        got       = 0;
        // every cycle up to the one after the final strobe
        repeat (total * n + 4) begin
            @(negedge clk);
            d         = cycle - t_en - 2;
            exp_valid = (d > 0) && (d % n == 0) && (d / n <= total);
            exp_busy  = (cycle > t_en) && (cycle <= last);
            compare_flag(out_valid, exp_valid,
                         $sformatf("job %0d out_valid at +%0d", j, cycle - t_en));
            compare_flag(busy, exp_busy, $sformatf("job %0d busy at +%0d", j, cycle - t_en));
            if (out_valid) begin
                check_row(out_row, model_row(jc, got), $sformatf("job %0d result %0d", j, got));
                got++;
            end
            @(posedge clk);
            #1;
            en = job_tab[j].poke && (cycle == t_en + 5);   // start while busy
        end
        check_count(dim_t'(got), dim_t'(total), $sformatf("job %0d result count", j));
    endtask

    ////////////////////
    // main
    ////////////////////
    initial begin
        rst_n  = 1'b0;
        en     = 1'b0;
        cfg    = '0;
        pix_wr = '0;
        wgt_wr = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            compare_flag(busy, 1'b0, "busy after reset");
            compare_flag(out_valid, 1'b0, "out_valid after reset");
        end
        for (int j = 0; j < n_jobs; j++) run_job(j);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = job_budget();
        wait (cycle >= limit);
        $display("timeout: run still going after %0d cycles", limit);
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

endmodule
